// File: bench/spy_assert.sv
// Spy port bound checks

`timescale 1ns/1ps
`default_nettype none

module spy_assert (
   input logic clk,
   input logic reset,
   input logic bus_read,
   input logic bus_write,
   input logic resp_valid,
   input logic txd,
   input logic tx_busy
);

   int fail_excl = 0;
   int fail_resp = 0;
   int fail_idle = 0;

   //////////////////////////////
   // Bus strobes
   //////////////////////////////

   a_strobe_excl: assert property (@(posedge clk) disable iff (reset)
      !(bus_read && bus_write))
      else begin
         $error("bus_read and bus_write high in the same cycle");
         fail_excl++;
      end

   // Response exactly one cycle after the read strobe
   a_resp_after_read: assert property (@(posedge clk) disable iff (reset)
      bus_read |=> resp_valid)
      else begin
         $error("resp_valid missing one cycle after bus_read");
         fail_resp++;
      end

   a_resp_only_after_read: assert property (@(posedge clk) disable iff (reset)
      resp_valid |-> $past(bus_read))
      else begin
         $error("resp_valid without bus_read in the cycle before");
         fail_resp++;
      end

   //////////////////////////////
   // Serial line
   //////////////////////////////

   a_txd_idle_high: assert property (@(posedge clk) disable iff (reset)
      !tx_busy |-> txd)
      else begin
         $error("txd low while the transmitter is idle");
         fail_idle++;
      end

endmodule

bind spy_top spy_assert u_spy_assert (
   .clk        (clk),
   .reset      (reset),
   .bus_read   (bus_read),
   .bus_write  (bus_write),
   .resp_valid (resp_valid),
   .txd        (txd),
   .tx_busy    (tx_busy)
);

`default_nettype wire

// File: bench/spy_clock_gen.sv
// Testbench clock and reset

`timescale 1ns/1ps
`default_nettype none

module spy_clock_gen #(
   parameter int PERIOD_NS    = 40,
   parameter int RESET_CYCLES = 16
) (
   output logic clk,
   output logic reset
);

   initial begin
      clk = 1'b0;
      forever #(PERIOD_NS / 2) clk = ~clk;
   end

   // Released on a falling edge, like all other stimulus
   initial begin
      reset = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
   end

endmodule

`default_nettype wire

// File: bench/spy_tb.sv
// Spy port testbench

`timescale 1ns/1ps
`default_nettype none

`include "spy_params.svh"

module spy_tb;
   import spy_pkg::*;

   localparam int CPB          = `SPY_CLKS_PER_BIT;
   localparam int NUM_SLOTS    = `SPY_NUM_SLOTS;
   localparam int FRAME_CYCLES = 10 * CPB;
   // Frames sent or received over all tests
   localparam int TOTAL_FRAMES = 106;
   localparam longint WATCHDOG_NS = longint'(TOTAL_FRAMES) * FRAME_CYCLES * 40 * 2;

   logic clk;
   logic reset;
   logic rxd;
   logic txd;
   logic [NUM_SLOTS-1:0][`SPY_WORD_W-1:0] status_in;
   logic [NUM_SLOTS-1:0][`SPY_WORD_W-1:0] ctl_out;

   // Reference model of the host-visible state
   spy_word_t   ref_data;
   spy_word_t   ref_ctl [NUM_SLOTS];
   logic [15:0] lfsr;

   int test_errors  = 0;
   int total_errors = 0;
   int tests_run    = 0;
   int tests_failed = 0;
   int assert_seen  = 0;

   spy_clock_gen u_clock_gen (
      .clk   (clk),
      .reset (reset)
   );

   spy_top u_spy_top (
      .clk       (clk),
      .reset     (reset),
      .rxd       (rxd),
      .txd       (txd),
      .status_in (status_in),
      .ctl_out   (ctl_out)
   );

   //////////////////////////////
   // Helpers
   //////////////////////////////

   // x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   task automatic rand_bits(input int n, output logic [15:0] val);
      val = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_step(lfsr);
         val  = {val[14:0], lfsr[0]};
      end
   endtask

   function automatic int assert_fails();
      return u_spy_top.u_spy_assert.fail_excl + u_spy_top.u_spy_assert.fail_resp +
             u_spy_top.u_spy_assert.fail_idle;
   endfunction

   task automatic check_value(input string name, input logic [15:0] exp,
                              input logic [15:0] got);
      assert (got === exp) else begin
         $display("FAIL t=%0t %s expected=%h actual=%h", $time, name, exp, got);
         test_errors++;
      end
   endtask

   task automatic check_all_ctl();
      for (int k = 0; k < NUM_SLOTS; k++)
         check_value($sformatf("ctl_out[%0d]", k), ref_ctl[k], ctl_out[k]);
   endtask

   task automatic settle();
      repeat (CPB) @(negedge clk);
   endtask

   // 8N1 frame, one bit per CPB cycles
   task automatic send_byte(input spy_byte_t b);
      logic [9:0] frame;
      frame = {1'b1, b, 1'b0};
      for (int i = 0; i < 10; i++) begin
         @(negedge clk);
         rxd = frame[i];
         repeat (CPB - 1) @(negedge clk);
      end
   endtask

   task automatic recv_byte(input int limit, output spy_byte_t b, output logic got);
      int waited;
      b      = '0;
      got    = 1'b0;
      waited = 0;
      while (txd !== 1'b0 && waited < limit) begin
         @(negedge clk);
         waited++;
      end
      if (txd === 1'b0) begin
         got = 1'b1;
         // Middle of the start bit, then whole bits
         repeat (CPB / 2) @(negedge clk);
         for (int i = 0; i < 8; i++) begin
            repeat (CPB) @(negedge clk);
            b = {txd, b[7:1]};
         end
         repeat (CPB) @(negedge clk);
         check_value("txd stop bit", 16'h0001, {15'd0, txd});
      end
   endtask

   task automatic load_data(input spy_word_t w);
      send_byte({op_data3, w[15:12]});
      send_byte({op_data2, w[11:8]});
      send_byte({op_data1, w[7:4]});
      send_byte({op_data0, w[3:0]});
      ref_data = w;
   endtask

   task automatic write_slot(input spy_addr_t addr);
      send_byte({op_wr_ctl, addr});
      if (int'(addr) < NUM_SLOTS)
         ref_ctl[int'(addr)] = ref_data;
   endtask

   // Reply bytes are 0x3n..0x6n, most significant nibble first
   task automatic read_check(input spy_op_t op, input spy_addr_t addr, input spy_word_t exp);
      spy_byte_t b;
      logic      got;
      send_byte({op, addr});
      for (int i = 0; i < 4; i++) begin
         recv_byte(2 * FRAME_CYCLES, b, got);
         assert (got) else begin
            $display("t=%0t reply byte %0d for slot %0d never arrived", $time, i, addr);
            test_errors++;
         end
         if (!got)
            break;
         check_value($sformatf("txd reply byte %0d", i),
                     {8'h00, 4'(i + 3), exp[(15 - 4 * i) -: 4]}, {8'h00, b});
      end
   endtask

   task automatic end_test(input string name);
      int errs;
      errs        = test_errors + assert_fails() - assert_seen;
      assert_seen = assert_fails();
      tests_run++;
      total_errors += errs;
      if (errs == 0) begin
         $display("test %0d %s: passed", tests_run, name);
      end else begin
         tests_failed++;
         $display("test %0d %s: failed with %0d errors", tests_run, name, errs);
      end
      test_errors = 0;
   endtask

   //////////////////////////////
   // Tests
   //////////////////////////////

   task automatic test_reset_state();
      for (int i = 0; i < 2 * FRAME_CYCLES; i++) begin
         @(negedge clk);
         check_value("txd", 16'h0001, {15'd0, txd});
      end
      check_all_ctl();
      end_test("reset_state");
   endtask

   task automatic test_write_read();
      spy_word_t w;
      for (int k = 0; k < NUM_SLOTS; k++) begin
         rand_bits(16, w);
         load_data(w);
         write_slot(spy_addr_t'(k));
         settle();
         check_all_ctl();
         read_check(op_rd_ctl, spy_addr_t'(k), ref_ctl[k]);
      end
      end_test("write_read");
   endtask

   task automatic test_status_read();
      spy_word_t w;
      for (int k = 0; k < NUM_SLOTS; k++) begin
         rand_bits(16, w);
         @(negedge clk);
         status_in[k] = w;
         read_check(op_rd_status, spy_addr_t'(k), w);
      end
      end_test("status_read");
   endtask

   task automatic test_isolation();
      logic [15:0] r;
      spy_addr_t   oor;
      spy_word_t   w;
      if (NUM_SLOTS < 16) begin
         rand_bits(4, r);
         oor = spy_addr_t'(NUM_SLOTS + int'(r) % (16 - NUM_SLOTS));
         read_check(op_rd_ctl, oor, '0);
         read_check(op_rd_status, oor, '0);
         rand_bits(16, w);
         load_data(w);
         write_slot(oor);
         settle();
         check_all_ctl();
      end
      // One slot changes, the rest hold
      rand_bits(4, r);
      write_slot(spy_addr_t'(int'(r) % NUM_SLOTS));
      settle();
      check_all_ctl();
      end_test("isolation");
   endtask

   task automatic test_ignored();
      logic [3:0]  ops [9];
      logic [15:0] r;
      spy_byte_t   b;
      logic        got;
      ops = '{4'h0, 4'h1, 4'h2, 4'h7, 4'hb, 4'hc, 4'hd, 4'he, 4'hf};
      foreach (ops[i]) begin
         rand_bits(4, r);
         send_byte({ops[i], r[3:0]});
         recv_byte(2 * FRAME_CYCLES, b, got);
         assert (!got) else begin
            $display("t=%0t opcode %h gave an unexpected reply", $time, ops[i]);
            test_errors++;
         end
      end
      check_all_ctl();
      // Written word shows the data register survived
      rand_bits(4, r);
      write_slot(spy_addr_t'(int'(r) % NUM_SLOTS));
      settle();
      check_all_ctl();
      end_test("ignored_opcodes");
   endtask

   //////////////////////////////
   // Sequence and watchdog
   //////////////////////////////

   initial begin
      rxd       = 1'b1;
      status_in = '0;
      ref_data  = '0;
      lfsr      = 16'd45;
      foreach (ref_ctl[k])
         ref_ctl[k] = '0;
      @(negedge clk);
      while (reset)
         @(negedge clk);
      test_reset_state();
      test_write_read();
      test_status_read();
      test_isolation();
      test_ignored();
      $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errors);
      if (tests_failed == 0 && total_errors == 0)
         $display("** PASS **");
      else
         $display("** FAIL **");
      $finish;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("t=%0t watchdog expired before the tests finished", $time);
      $display("** FAIL **");
      $finish;
   end

endmodule

`default_nettype wire

// File: compile.f
+incdir+src
src/spy_pkg.sv
src/spy_uart_rx.sv
src/spy_uart_tx.sv
src/spy_cmd.sv
src/spy_reg_slot.sv
src/spy_read_mux.sv
src/spy_top.sv
bench/spy_clock_gen.sv
bench/spy_assert.sv
bench/spy_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the spy port simulation with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module spy_tb \
   -f compile.f -Mdir obj_dir -o spy_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/spy_sim +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q -F -x '** PASS **' "$LOG"; then
   exit 0
fi
echo "Pass line not found in $LOG"
exit 1

// File: src/spy_cmd.sv
// Spy command interpreter

`timescale 1ns/1ps
`default_nettype none

module spy_cmd (
   input  logic               clk,
   input  logic               reset,
   input  logic               rx_valid,
   input  spy_pkg::spy_byte_t rx_byte,
   input  logic               tx_busy,
   output logic               tx_start,
   output spy_pkg::spy_byte_t tx_byte,
   output spy_pkg::spy_addr_t bus_addr,
   output spy_pkg::spy_word_t bus_wdata,
   output logic               bus_write,
   output logic               bus_read,
   output logic               bus_sel_status,
   input  spy_pkg::spy_word_t resp_word,
   input  logic               resp_valid
);
   import spy_pkg::*;

   spy_cmd_state_t state;
   spy_op_t        op;
   spy_word_t      data_reg;
   spy_word_t      reply;
   logic [1:0]     nib_idx;
   logic [3:0]     nibble;
   logic [3:0]     prefix;

   assign op        = spy_op_t'(rx_byte[7:4]);
   assign bus_wdata = data_reg;

   //////////////////////////////
   // Command decode and bus
   //////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         state          <= cmd_idle;
         data_reg       <= '0;
         bus_addr       <= '0;
         bus_write      <= 1'b0;
         bus_read       <= 1'b0;
         bus_sel_status <= 1'b0;
         nib_idx        <= '0;
      end else begin
         bus_write <= 1'b0;
         bus_read  <= 1'b0;
         case (state)
            cmd_idle: begin
               // Bytes are only taken here
               if (rx_valid) begin
                  case (op)
                     op_data3: data_reg[15:12] <= rx_byte[3:0];
                     op_data2: data_reg[11:8]  <= rx_byte[3:0];
                     op_data1: data_reg[7:4]   <= rx_byte[3:0];
                     op_data0: data_reg[3:0]   <= rx_byte[3:0];
                     op_rd_status, op_rd_ctl: begin
                        bus_addr       <= rx_byte[3:0];
                        bus_sel_status <= (op == op_rd_status);
                        bus_read       <= 1'b1;
                        state          <= cmd_resp;
                     end
                     op_wr_ctl: begin
                        bus_addr  <= rx_byte[3:0];
                        bus_write <= 1'b1;
                     end
                     default: ;
                  endcase
               end
            end
            cmd_resp: begin
               if (resp_valid) begin
                  nib_idx <= '0;
                  state   <= cmd_send;
               end
            end
            // One send and two waits per reply byte
            cmd_send: state <= cmd_wait_hi;
            cmd_wait_hi: begin
               if (tx_busy)
                  state <= cmd_wait_lo;
            end
            cmd_wait_lo: begin
               if (!tx_busy) begin
                  if (nib_idx == 2'd3) begin
                     state <= cmd_idle;
                  end else begin
                     nib_idx <= nib_idx + 1'b1;
                     state   <= cmd_send;
                  end
               end
            end
            default: state <= cmd_idle;
         endcase
      end
   end

   // Response word held through the reply
   always_ff @(posedge clk) begin
      if (state == cmd_resp && resp_valid)
         reply <= resp_word;
   end

   //////////////////////////////
   // Reply byte
   //////////////////////////////

   always_comb begin
      case (nib_idx)
         2'd0:    nibble = reply[15:12];
         2'd1:    nibble = reply[11:8];
         2'd2:    nibble = reply[7:4];
         default: nibble = reply[3:0];
      endcase
   end

   // Prefix runs 3 to 6, most significant nibble first
   assign prefix   = 4'h3 + {2'b00, nib_idx};
   assign tx_byte  = {prefix, nibble};
   assign tx_start = (state == cmd_send);

endmodule

`default_nettype wire

// File: src/spy_params.svh
// Spy port parameters

`ifndef SPY_PARAMS_SVH
`define SPY_PARAMS_SVH

// Number of debug slots, at most 16
`define SPY_NUM_SLOTS 4

// Data, control and status word width
`define SPY_WORD_W 16

// Clock cycles per serial bit
`define SPY_CLKS_PER_BIT 8

`endif

// File: src/spy_pkg.sv
// Spy port types

`default_nettype none

`include "spy_params.svh"

package spy_pkg;

   typedef logic [`SPY_WORD_W-1:0] spy_word_t;
   typedef logic [3:0]             spy_addr_t;
   typedef logic [7:0]             spy_byte_t;

   // Upper nibble of a command byte
   typedef enum logic [3:0] {
      op_data3     = 4'h3,
      op_data2     = 4'h4,
      op_data1     = 4'h5,
      op_data0     = 4'h6,
      op_rd_status = 4'h8,
      op_rd_ctl    = 4'h9,
      op_wr_ctl    = 4'ha
   } spy_op_t;

   typedef enum logic [2:0] {
      cmd_idle,
      cmd_resp,
      cmd_send,
      cmd_wait_hi,
      cmd_wait_lo
   } spy_cmd_state_t;

   typedef enum logic [1:0] {
      rxs_idle,
      rxs_start,
      rxs_data,
      rxs_stop
   } uart_rx_state_t;

   typedef enum logic {
      txs_idle,
      txs_shift
   } uart_tx_state_t;

endpackage

`default_nettype wire

// File: src/spy_read_mux.sv
// Spy read selector

`timescale 1ns/1ps
`default_nettype none

`include "spy_params.svh"

module spy_read_mux (
   input  logic                                      clk,
   input  logic                                      reset,
   input  logic                                      bus_read,
   input  logic                                      bus_sel_status,
   input  spy_pkg::spy_addr_t                        bus_addr,
   input  logic [`SPY_NUM_SLOTS-1:0][`SPY_WORD_W-1:0] ctl_words,
   input  logic [`SPY_NUM_SLOTS-1:0][`SPY_WORD_W-1:0] status_words,
   output spy_pkg::spy_word_t                        resp_word,
   output logic                                      resp_valid
);
   import spy_pkg::*;

   spy_word_t sel_word;

   always_comb begin
      sel_word = '0;
      // Unpopulated addresses read as zero
      for (int i = 0; i < `SPY_NUM_SLOTS; i++) begin
         if (bus_addr == spy_addr_t'(i))
            sel_word = bus_sel_status ? status_words[i] : ctl_words[i];
      end
   end

   always_ff @(posedge clk) begin
      if (bus_read)
         resp_word <= sel_word;
   end

   always_ff @(posedge clk) begin
      if (reset)
         resp_valid <= 1'b0;
      else
         resp_valid <= bus_read;
   end

endmodule

`default_nettype wire

// File: src/spy_reg_slot.sv
// Spy debug slot

`timescale 1ns/1ps
`default_nettype none

module spy_reg_slot #(
   parameter int SLOT_INDEX = 0
) (
   input  logic               clk,
   input  logic               reset,
   input  logic               bus_write,
   input  spy_pkg::spy_addr_t bus_addr,
   input  spy_pkg::spy_word_t bus_wdata,
   input  spy_pkg::spy_word_t status_in,
   output spy_pkg::spy_word_t ctl_word,
   output spy_pkg::spy_word_t status_sync
);
   import spy_pkg::*;

   logic      hit;
   spy_word_t status_meta;

   assign hit = bus_write && (bus_addr == spy_addr_t'(SLOT_INDEX));

   always_ff @(posedge clk) begin
      if (reset)
         ctl_word <= '0;
      else if (hit)
         ctl_word <= bus_wdata;
   end

   // Two flops for the asynchronous status word
   always_ff @(posedge clk) begin
      status_meta <= status_in;
      status_sync <= status_meta;
   end

endmodule

`default_nettype wire

// File: src/spy_top.sv
// Spy port top level

`timescale 1ns/1ps
`default_nettype none

`include "spy_params.svh"

module spy_top (
   input  logic                                      clk,
   input  logic                                      reset,
   input  logic                                      rxd,
   output logic                                      txd,
   input  logic [`SPY_NUM_SLOTS-1:0][`SPY_WORD_W-1:0] status_in,
   output logic [`SPY_NUM_SLOTS-1:0][`SPY_WORD_W-1:0] ctl_out
);
   import spy_pkg::*;

   spy_byte_t rx_byte;
   logic      rx_valid;
   spy_byte_t tx_byte;
   logic      tx_start;
   logic      tx_busy;
   spy_addr_t bus_addr;
   spy_word_t bus_wdata;
   logic      bus_write;
   logic      bus_read;
   logic      bus_sel_status;
   spy_word_t resp_word;
   logic      resp_valid;

   logic [`SPY_NUM_SLOTS-1:0][`SPY_WORD_W-1:0] status_sync;

   //////////////////////////////
   // Serial side
   //////////////////////////////

   spy_uart_rx u_uart_rx (
      .clk      (clk),
      .reset    (reset),
      .rxd      (rxd),
      .rx_byte  (rx_byte),
      .rx_valid (rx_valid)
   );

   spy_uart_tx u_uart_tx (
      .clk      (clk),
      .reset    (reset),
      .tx_start (tx_start),
      .tx_byte  (tx_byte),
      .txd      (txd),
      .tx_busy  (tx_busy)
   );

   spy_cmd u_cmd (
      .clk            (clk),
      .reset          (reset),
      .rx_valid       (rx_valid),
      .rx_byte        (rx_byte),
      .tx_busy        (tx_busy),
      .tx_start       (tx_start),
      .tx_byte        (tx_byte),
      .bus_addr       (bus_addr),
      .bus_wdata      (bus_wdata),
      .bus_write      (bus_write),
      .bus_read       (bus_read),
      .bus_sel_status (bus_sel_status),
      .resp_word      (resp_word),
      .resp_valid     (resp_valid)
   );

   //////////////////////////////
   // Register side
   //////////////////////////////

   for (genvar gi = 0; gi < `SPY_NUM_SLOTS; gi++) begin : g_slot
      spy_reg_slot #(
         .SLOT_INDEX (gi)
      ) u_slot (
         .clk         (clk),
         .reset       (reset),
         .bus_write   (bus_write),
         .bus_addr    (bus_addr),
         .bus_wdata   (bus_wdata),
         .status_in   (status_in[gi]),
         .ctl_word    (ctl_out[gi]),
         .status_sync (status_sync[gi])
      );
   end

   spy_read_mux u_read_mux (
      .clk            (clk),
      .reset          (reset),
      .bus_read       (bus_read),
      .bus_sel_status (bus_sel_status),
      .bus_addr       (bus_addr),
      .ctl_words      (ctl_out),
      .status_words   (status_sync),
      .resp_word      (resp_word),
      .resp_valid     (resp_valid)
   );

endmodule

`default_nettype wire

// File: src/spy_uart_rx.sv
// UART receiver

`timescale 1ns/1ps
`default_nettype none

`include "spy_params.svh"

module spy_uart_rx (
   input  logic               clk,
   input  logic               reset,
   input  logic               rxd,
   output spy_pkg::spy_byte_t rx_byte,
   output logic               rx_valid
);
   import spy_pkg::*;

   localparam int CPB   = `SPY_CLKS_PER_BIT;
   localparam int CNT_W = $clog2(CPB + 1);

   uart_rx_state_t   state;
   logic             rxd_meta;
   logic             rxd_sync;
   logic             rxd_prev;
   logic [CNT_W-1:0] cnt;
   logic [2:0]       bit_idx;
   spy_byte_t        shreg;
   logic             bit_end;
   logic             half_bit;

   assign bit_end  = (cnt == CNT_W'(CPB - 1));
   assign half_bit = (cnt == CNT_W'(CPB / 2 - 1));

   // Line synchronizer, idles high
   always_ff @(posedge clk) begin
      if (reset) begin
         rxd_meta <= 1'b1;
         rxd_sync <= 1'b1;
         rxd_prev <= 1'b1;
      end else begin
         rxd_meta <= rxd;
         rxd_sync <= rxd_meta;
         rxd_prev <= rxd_sync;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state    <= rxs_idle;
         cnt      <= '0;
         bit_idx  <= '0;
         rx_valid <= 1'b0;
      end else begin
         rx_valid <= 1'b0;
         cnt      <= cnt + 1'b1;
         case (state)
            rxs_idle: begin
               cnt <= '0;
               // Falling edge starts a frame
               if (rxd_prev && !rxd_sync)
                  state <= rxs_start;
            end
            rxs_start: begin
               if (half_bit) begin
                  cnt     <= '0;
                  bit_idx <= '0;
                  state   <= rxd_sync ? rxs_idle : rxs_data;
               end
            end
            rxs_data: begin
               if (bit_end) begin
                  cnt     <= '0;
                  bit_idx <= bit_idx + 1'b1;
                  if (bit_idx == 3'd7)
                     state <= rxs_stop;
               end
            end
            rxs_stop: begin
               if (bit_end) begin
                  // Low stop bit means a framing error
                  rx_valid <= rxd_sync;
                  state    <= rxs_idle;
               end
            end
            default: state <= rxs_idle;
         endcase
      end
   end

   // LSB first, shift in from the top
   always_ff @(posedge clk) begin
      if (state == rxs_data && bit_end)
         shreg <= {rxd_sync, shreg[7:1]};
      if (state == rxs_stop && bit_end)
         rx_byte <= shreg;
   end

endmodule

`default_nettype wire

// File: src/spy_uart_tx.sv
// UART transmitter

`timescale 1ns/1ps
`default_nettype none

`include "spy_params.svh"

module spy_uart_tx (
   input  logic               clk,
   input  logic               reset,
   input  logic               tx_start,
   input  spy_pkg::spy_byte_t tx_byte,
   output logic               txd,
   output logic               tx_busy
);
   import spy_pkg::*;

   localparam int CPB   = `SPY_CLKS_PER_BIT;
   localparam int CNT_W = $clog2(CPB + 1);

   uart_tx_state_t   state;
   logic [9:0]       frame;
   logic [CNT_W-1:0] cnt;
   logic [3:0]       bit_cnt;

   // Line follows the low end of the frame
   assign txd = frame[0];

   always_ff @(posedge clk) begin
      if (reset) begin
         state   <= txs_idle;
         frame   <= '1;
         cnt     <= '0;
         bit_cnt <= '0;
         tx_busy <= 1'b0;
      end else begin
         case (state)
            txs_idle: begin
               if (tx_start) begin
                  // Stop, data, start
                  frame   <= {1'b1, tx_byte, 1'b0};
                  cnt     <= '0;
                  bit_cnt <= '0;
                  tx_busy <= 1'b1;
                  state   <= txs_shift;
               end
            end
            txs_shift: begin
               cnt <= cnt + 1'b1;
               if (cnt == CNT_W'(CPB - 1)) begin
                  cnt     <= '0;
                  frame   <= {1'b1, frame[9:1]};
                  bit_cnt <= bit_cnt + 1'b1;
                  if (bit_cnt == 4'd9) begin
                     tx_busy <= 1'b0;
                     state   <= txs_idle;
                  end
               end
            end
            default: state <= txs_idle;
         endcase
      end
   end

endmodule

`default_nettype wire
